// File: sim.f
hw/img_capture_pkg.sv
hw/pixel_input_stage.sv
hw/capture_sequencer.sv
hw/fletcher_checksum.sv
hw/pixel_stats.sv
hw/img_capture_top.sv
tests/img_capture_tb.sv

// File: tests/img_capture_tb.sv
`default_nettype none

module img_capture_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import img_capture_pkg::*;

    localparam int header_words = 8;
    localparam int count_w      = $clog2(65536 + 1);
    localparam int porch        = 2;
    localparam int line_gap     = 3;
    localparam int frame_gap    = 6;

    // Beats one frame takes on the pins with room for a command beat
    function automatic int frame_cycles(input int lines, input int cols);
        return porch + lines * (cols + line_gap + 1) + frame_gap;
    endfunction

    localparam int timeout_limit =
        2 * (frame_cycles(9, 10) + frame_cycles(8, 10) + frame_cycles(6, 13)) + 2000;

    logic                     clk;
    logic                     rst_n;
    logic                     cmd_capture;
    word_t [header_words-1:0] cmd_header;
    pixel_t                   img_d;
    logic                     img_fv;
    logic                     img_lv;
    logic                     out_valid;
    word_t                    out_data;
    logic                     capture_done;
    logic                     busy;
    logic [count_w-1:0]       word_count;
    stat_count_t              highlight_count;
    stat_count_t              shadow_count;

    // ============================================================
    // Reference model state
    // ============================================================
    logic [15:0]              lfsr;
    logic [16:0]              expect_q[$];    // {last word, data}
    word_t [header_words-1:0] header_val;
    int                       fl_a;
    int                       fl_b;
    int                       exp_words;
    int                       exp_high;
    int                       exp_shadow;
    int                       cycle_count = 0;
    logic                     done_seen;

    img_capture_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_capture     (cmd_capture),
        .cmd_header      (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .capture_done    (capture_done),
        .busy            (busy),
        .word_count      (word_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    task automatic abort_run(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic drive_beat(input logic fv, input logic lv, input pixel_t d, input logic cmd);
        @(posedge clk);
        img_fv      <= fv;
        img_lv      <= lv;
        img_d       <= d;
        cmd_capture <= cmd;
        cmd_header  <= header_val;
    endtask

    // Queue a word and fold it into the Fletcher-32 model
    task automatic expect_word(input word_t w, input logic summed, input logic last);
        expect_q.push_back({last, w});
        exp_words++;
        if (summed) begin
            fl_a = (fl_a + w) % 65535;
            fl_b = (fl_b + fl_a) % 65535;
        end
    endtask

    task automatic arm_capture();
        logic [15:0] r;
        fl_a       = 0;
        fl_b       = 0;
        exp_words  = 0;
        exp_high   = 0;
        exp_shadow = 0;
        done_seen  = 1'b0;
        // Word 0 travels in the top slot
        for (int i = 0; i < header_words; i++) begin
            r = take_bits(16);
            header_val[header_words-1-i] = r;
            expect_word(r, 1'b1, 1'b0);
        end
    endtask

    task automatic expect_checksum();
        logic [15:0] a;
        logic [15:0] b;
        a = fl_a[15:0];
        b = fl_b[15:0];
        expect_word({a[7:0], a[15:8]}, 1'b0, 1'b0);
        expect_word({b[7:0], b[15:8]}, 1'b0, 1'b1);
    endtask

    // One frame of lines with blanking and an optional command before line cmd_line
    task automatic drive_frame(input int lines, input int cols, input logic captured,
                               input int cmd_line);
        pixel_t      px;
        logic [15:0] r;
        logic [15:0] pick;
        logic        sampled;
        repeat (porch) drive_beat(1'b1, 1'b0, '0, 1'b0);
        for (int l = 0; l < lines; l++) begin
            if (l == cmd_line) begin
                arm_capture();
                drive_beat(1'b1, 1'b0, '0, 1'b1);
            end
            for (int c = 0; c < cols; c++) begin
                sampled = (l % 4 == 0) && (c % 4 == 0);
                r       = take_bits(12);
                px      = r[11:0];
                if (sampled) begin
                    pick = take_bits(2);
                    if (pick[1:0] == 2'd0)
                        px[11:5] = 7'h7f;
                    else if (pick[1:0] == 2'd1)
                        px[11:5] = 7'h00;
                end
                if (captured) begin
                    expect_word({px[7:0], 4'h0, px[11:8]}, 1'b1, 1'b0);
                    if (sampled && px[11:5] == 7'h7f)
                        exp_high++;
                    else if (sampled && px[11:5] == 7'h00)
                        exp_shadow++;
                end
                drive_beat(1'b1, 1'b1, px, 1'b0);
            end
            repeat (line_gap) drive_beat(1'b1, 1'b0, '0, 1'b0);
        end
        if (captured)
            expect_checksum();
        repeat (frame_gap) drive_beat(1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic check_idle(input int beats);
        repeat (beats) begin
            drive_beat(1'b0, 1'b0, '0, 1'b0);
            @(negedge clk);
            assert (!out_valid && !capture_done && !busy)
                else abort_run("stream or status active before any command");
            assert (word_count == 0 && highlight_count == 0 && shadow_count == 0)
                else abort_run("counts not zero after reset");
        end
    endtask

    task automatic finish_capture();
        while (!done_seen)
            drive_beat(1'b0, 1'b0, '0, 1'b0);
        repeat (2) drive_beat(1'b0, 1'b0, '0, 1'b0);
        @(negedge clk);
        assert (expect_q.size() == 0)
            else abort_run($sformatf("%0d expected words never arrived", expect_q.size()));
        assert (!busy) else abort_run("busy still high after capture_done");
        assert (word_count == count_w'(exp_words))
            else abort_run($sformatf("word_count %0d, expected %0d", word_count, exp_words));
        assert (highlight_count == stat_count_t'(exp_high))
            else abort_run($sformatf("highlight_count %0d, expected %0d",
                                     highlight_count, exp_high));
        assert (shadow_count == stat_count_t'(exp_shadow))
            else abort_run($sformatf("shadow_count %0d, expected %0d", shadow_count, exp_shadow));
    endtask

    // ============================================================
    // Stream checker
    // ============================================================
    always @(negedge clk) begin : stream_check
        logic [16:0] exp;
        if (rst_n) begin
            if (out_valid) begin
                assert (expect_q.size() != 0) else abort_run("word emitted with none expected");
                exp = expect_q.pop_front();
                assert (out_data == exp[15:0])
                    else abort_run($sformatf("out_data %h, expected %h", out_data, exp[15:0]));
                assert (capture_done == exp[16])
                    else abort_run($sformatf("capture_done %b on word %h", capture_done, out_data));
                if (capture_done)
                    done_seen = 1'b1;
            end else begin
                assert (!capture_done) else abort_run("capture_done without a word");
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> busy)
        else abort_run("word emitted while not busy");

    assert property (@(posedge clk) disable iff (!rst_n) $fell(busy) |-> $past(capture_done))
        else abort_run("busy fell without capture_done");

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Run timed out after %0d cycles without finishing", cycle_count);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cmd_capture = 1'b0;
        cmd_header  = '0;
        header_val  = '0;
        img_d       = '0;
        img_fv      = 1'b0;
        img_lv      = 1'b0;
        lfsr        = 16'd12;
        done_seen   = 1'b0;
        fl_a        = 0;
        fl_b        = 0;
        exp_words   = 0;
        exp_high    = 0;
        exp_shadow  = 0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_idle(10);

        // Capture armed while the sensor is blank
        arm_capture();
        drive_beat(1'b0, 1'b0, '0, 1'b1);
        repeat (16) drive_beat(1'b0, 1'b0, '0, 1'b0);
        drive_frame(9, 10, 1'b1, -1);
        finish_capture();

        // A command mid-frame skips that frame and captures the next one
        drive_frame(8, 10, 1'b0, 1);
        drive_frame(6, 13, 1'b1, -1);
        finish_capture();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/img_capture_top.sv
`default_nettype none

module img_capture_top #(
    parameter int  header_words    = 8,
    parameter int  max_image_words = 65536,
    localparam int count_w         = $clog2(max_image_words + 1)
) (
    input  wire                                       clk,
    input  wire                                       rst_n,

    // Command
    input  wire                                       cmd_capture,
    input  img_capture_pkg::word_t [header_words-1:0] cmd_header,

    // Sensor pins
    input  img_capture_pkg::pixel_t                   img_d,
    input  wire                                       img_fv,
    input  wire                                       img_lv,

    // Word stream towards the RAM writer
    output logic                                      out_valid,
    output img_capture_pkg::word_t                    out_data,

    // Status
    output logic                                      capture_done,
    output logic                                      busy,
    output logic [count_w-1:0]                        word_count,
    output img_capture_pkg::stat_count_t              highlight_count,
    output img_capture_pkg::stat_count_t              shadow_count
);
    import img_capture_pkg::*;

    pixel_beat_t pix;
    word_beat_t  word;
    checksum_t   checksum;
    logic        clear;
    logic        frame_active;

    // ============================================================
    // Input sampling
    // ============================================================
    pixel_input_stage u_input (
        .clk    (clk),
        .rst_n  (rst_n),
        .img_d  (img_d),
        .img_fv (img_fv),
        .img_lv (img_lv),
        .pix    (pix)
    );

    // ============================================================
    // Sequencing with checksum and statistics alongside
    // ============================================================
    capture_sequencer #(
        .header_words    (header_words),
        .max_image_words (max_image_words)
    ) u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_capture  (cmd_capture),
        .cmd_header   (cmd_header),
        .pix          (pix),
        .checksum     (checksum),
        .word         (word),
        .clear        (clear),
        .frame_active (frame_active),
        .busy         (busy),
        .capture_done (capture_done),
        .word_count   (word_count)
    );

    fletcher_checksum u_checksum (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .word     (word),
        .checksum (checksum)
    );

    pixel_stats u_stats (
        .clk             (clk),
        .rst_n           (rst_n),
        .clear           (clear),
        .frame_active    (frame_active),
        .pix             (pix),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    assign out_valid = word.valid;
    assign out_data  = word.data;

endmodule

`default_nettype wire

// File: hw/pixel_stats.sv
`default_nettype none

module pixel_stats (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          clear,
    input  wire                          frame_active,
    input  img_capture_pkg::pixel_beat_t pix,
    output img_capture_pkg::stat_count_t highlight_count,
    output img_capture_pkg::stat_count_t shadow_count
);
    import img_capture_pkg::*;

    // ============================================================
    // Sampled pixel classification
    // ============================================================
    logic count_en;

    assign count_en = frame_active && pix.sample;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (clear) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (count_en) begin
            // Only the top seven bits decide
            case (pix.data[11:5])
                highlight_code: highlight_count <= highlight_count + 1'b1;
                shadow_code:    shadow_count    <= shadow_count + 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Outside a clear, one pixel never lands in both bins
    assert property (@(posedge clk) disable iff (!rst_n)
        !$past(clear) |-> !($changed(highlight_count) && $changed(shadow_count)))
        else $error("highlight and shadow counts changed together");

endmodule

`default_nettype wire

// File: hw/fletcher_checksum.sv
`default_nettype none

module fletcher_checksum (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         clear,
    input  img_capture_pkg::word_beat_t word,
    output img_capture_pkg::checksum_t  checksum
);
    import img_capture_pkg::*;

    word_t sum_a;
    word_t sum_b;
    word_t a_next;

    // Add modulo 65535, both operands already reduced or a raw word
    function automatic word_t mod_add(input word_t x, input word_t y);
        logic [16:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= 17'd65535)
            s = s - 17'd65535;
        return s[15:0];
    endfunction

    assign a_next = mod_add(sum_a, word.data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (word.valid && word.sum) begin
            sum_a <= a_next;
            // B follows the new value of A
            sum_b <= mod_add(sum_b, a_next);
        end
    end

    assign checksum = {sum_b, sum_a};

    // Both sums remain reduced across every update
    assert property (@(posedge clk) disable iff (!rst_n)
        (sum_a != 16'hffff) && (sum_b != 16'hffff))
        else $error("fletcher sum left its modulo range");

endmodule

`default_nettype wire

// File: hw/capture_sequencer.sv
`default_nettype none

module capture_sequencer #(
    parameter int  header_words    = 8,
    parameter int  max_image_words = 65536,
    localparam int count_w         = $clog2(max_image_words + 1)
) (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire                                           cmd_capture,
    input  img_capture_pkg::word_t [header_words-1:0]     cmd_header,
    input  img_capture_pkg::pixel_beat_t                  pix,
    input  img_capture_pkg::checksum_t                    checksum,
    output img_capture_pkg::word_beat_t                   word,
    output logic                                          clear,
    output logic                                          frame_active,
    output logic                                          busy,
    output logic                                          capture_done,
    output logic [count_w-1:0]                            word_count
);
    import img_capture_pkg::*;

    localparam int hdr_w = (header_words > 1) ? $clog2(header_words) : 1;

    capture_state_t state;
    capture_state_t state_next;

    // Header words with word 0 in the top slot
    word_t [header_words-1:0] hdr_sr;
    logic [hdr_w-1:0]         hdr_left;

    // Decoded emission for the coming edge
    logic  emit;
    logic  emit_sum;
    word_t emit_data;
    word_t pixel_word;

    // Registered word stream
    logic  valid_q;
    logic  sum_q;
    word_t data_q;

    // Low byte of the pixel goes first on the wire
    assign pixel_word = {pix.data[7:0], 4'b0000, pix.data[11:8]};

    // Beats of the frame being captured
    assign frame_active = pix.fv && (state == cap_wait_start || state == cap_frame);

    // ============================================================
    // Next state and word selection
    // ============================================================
    always_comb begin
        state_next = state;
        emit       = 1'b0;
        emit_sum   = 1'b1;
        emit_data  = pixel_word;

        case (state)
            cap_idle: begin
            end

            cap_clear: begin
                state_next = cap_header;
            end

            cap_header: begin
                emit      = 1'b1;
                emit_data = hdr_sr[header_words-1];
                if (hdr_left == '0)
                    state_next = cap_wait_invalid;
            end

            // Skip a frame that was already running at the command
            cap_wait_invalid: begin
                if (!pix.fv)
                    state_next = cap_wait_start;
            end

            cap_wait_start: begin
                emit = frame_active && pix.lv;
                if (pix.fv)
                    state_next = cap_frame;
            end

            cap_frame: begin
                emit = frame_active && pix.lv;
                if (!pix.fv)
                    state_next = cap_checksum_lo;
            end

            // Checksum halves go out byte-swapped with sum A first
            cap_checksum_lo: begin
                emit       = 1'b1;
                emit_sum   = 1'b0;
                emit_data  = {checksum[7:0], checksum[15:8]};
                state_next = cap_checksum_hi;
            end

            cap_checksum_hi: begin
                emit       = 1'b1;
                emit_sum   = 1'b0;
                emit_data  = {checksum[23:16], checksum[31:24]};
                state_next = cap_idle;
            end

            default: begin
                state_next = cap_idle;
            end
        endcase

        // A new command wins over whatever is in flight
        if (cmd_capture) begin
            state_next = cap_clear;
            emit       = 1'b0;
        end
    end

    // ============================================================
    // Control registers
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= cap_idle;
            valid_q      <= 1'b0;
            clear        <= 1'b0;
            capture_done <= 1'b0;
            busy         <= 1'b0;
            hdr_left     <= '0;
            word_count   <= '0;
        end else begin
            state        <= state_next;
            valid_q      <= emit;
            clear        <= (state == cap_clear) && !cmd_capture;
            capture_done <= (state == cap_checksum_hi) && !cmd_capture;

            if (cmd_capture)
                busy <= 1'b1;
            else if (capture_done)
                busy <= 1'b0;

            if (state == cap_clear)
                hdr_left <= hdr_w'(header_words - 1);
            else if (state == cap_header)
                hdr_left <= hdr_left - 1'b1;

            // Checksum words are counted as well
            if (state == cap_clear)
                word_count <= '0;
            else if (valid_q)
                word_count <= word_count + 1'b1;
        end
    end

    // Header and word payload
    always_ff @(posedge clk) begin
        if (state == cap_clear)
            hdr_sr <= cmd_header;
        else if (state == cap_header)
            hdr_sr <= hdr_sr << $bits(word_t);
        sum_q  <= emit_sum;
        data_q <= emit_data;
    end

    assign word = '{valid: valid_q, sum: sum_q, data: data_q};

    // In idle the only word left on the stream is the closing checksum word
    assert property (@(posedge clk) disable iff (!rst_n)
        ((state == cap_idle) && valid_q) |-> capture_done)
        else $error("word emitted from idle");

    // Done rides on an unsummed checksum word
    assert property (@(posedge clk) disable iff (!rst_n)
        capture_done |-> (valid_q && !sum_q))
        else $error("capture_done outside checksum_hi");

endmodule

`default_nettype wire

// File: hw/pixel_input_stage.sv
`default_nettype none

module pixel_input_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    input  img_capture_pkg::pixel_t      img_d,
    input  wire                          img_fv,
    input  wire                          img_lv,
    output img_capture_pkg::pixel_beat_t pix
);
    import img_capture_pkg::*;

    // ============================================================
    // Pin registers
    // ============================================================
    logic   fv_q;
    logic   lv_q;
    logic   line_end_q;
    logic   sample_q;
    pixel_t data_q;

    // Position of the pixel now on the pins, modulo four
    logic [1:0] col_phase;
    logic [1:0] line_phase;

    // Registered lv is still high while the pin has already dropped
    logic lv_fall;

    assign lv_fall = lv_q && !img_lv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fv_q       <= 1'b0;
            lv_q       <= 1'b0;
            line_end_q <= 1'b0;
            sample_q   <= 1'b0;
            col_phase  <= 2'd0;
            line_phase <= 2'd0;
        end else begin
            fv_q       <= img_fv;
            lv_q       <= img_lv;
            line_end_q <= lv_fall;

            // Phases are taken before they advance for this pixel
            sample_q <= img_lv && (col_phase == 2'd0) && (line_phase == 2'd0);

            // Column phase restarts at every line
            if (!img_lv)
                col_phase <= 2'd0;
            else
                col_phase <= col_phase + 2'd1;

            // Line phase restarts at every frame
            if (!img_fv)
                line_phase <= 2'd0;
            else if (lv_fall)
                line_phase <= line_phase + 2'd1;
        end
    end

    // Pixel payload
    always_ff @(posedge clk) begin
        data_q <= img_d;
    end

    assign pix = '{
        fv:       fv_q,
        lv:       lv_q,
        line_end: line_end_q,
        sample:   sample_q,
        data:     data_q
    };

endmodule

`default_nettype wire

// File: hw/img_capture_pkg.sv
`default_nettype none

package img_capture_pkg;

    // ============================================================
    // Widths that carry a meaning
    // ============================================================

    // One sensor sample
    typedef logic [11:0] pixel_t;

    // One word of the capture stream
    typedef logic [15:0] word_t;

    // Highlight or shadow tally
    typedef logic [17:0] stat_count_t;

    // Fletcher-32 result, sum B in [31:16] and sum A in [15:0]
    typedef logic [31:0] checksum_t;

    // ============================================================
    // Bundles
    // ============================================================

    // Registered pixel beat from the input stage
    typedef struct packed {
        logic   fv;
        logic   lv;
        logic   line_end;   // first beat after lv falls
        logic   sample;     // column and line both multiples of four
        pixel_t data;
    } pixel_beat_t;

    // One emitted stream word
    typedef struct packed {
        logic  valid;
        logic  sum;         // word takes part in the checksum
        word_t data;
    } word_beat_t;

    // Capture sequencer states
    typedef enum logic [2:0] {
        cap_idle,
        cap_clear,
        cap_header,
        cap_wait_invalid,
        cap_wait_start,
        cap_frame,
        cap_checksum_lo,
        cap_checksum_hi
    } capture_state_t;

    // Top seven pixel bits used for classification
    localparam logic [6:0] highlight_code = 7'b111_1111;
    localparam logic [6:0] shadow_code    = 7'b000_0000;

endpackage

`default_nettype wire
